/* verilog/apbI2cPkg.sv */
// Shared types, FSM encodings and register map of the APB I2C master
// Offsets are byte addresses and decode on the full 32-bit PADDR
// Byte count field must be 1 to 15; a count of 0 is not supported
package apbI2cPkg;

	////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////

	// APB address or data word
	typedef logic [31:0] apbWord_t;
	// Configuration and timeout register contents
	typedef logic [13:0] cfgReg_t;
	// One byte on the I2C bus
	typedef logic [7:0] i2cByte_t;

	// Commands from the controller to the bit engine
	typedef enum logic [1:0] {CMD_START, CMD_STOP, CMD_WRITE, CMD_READ} engCmd_e;

	// Transfer FSM states
	typedef enum logic [2:0] {IDLE, START, ADDR, DATA, STOP, ABORT} ctrlState_e;

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////

	localparam apbWord_t OFS_TXDATA = 32'd0;
	localparam apbWord_t OFS_RXDATA = 32'd4;
	localparam apbWord_t OFS_CONFIG = 32'd8;
	localparam apbWord_t OFS_TIMEOUT = 32'd12;
	localparam apbWord_t OFS_STATUS = 32'd16;

	// Configuration fields, slave address sits in [6:0]
	localparam int CFG_ADDR_MSB = 6;
	localparam int CFG_READ_BIT = 7;
	localparam int CFG_CNT_LSB = 8;
	localparam int CFG_CNT_MSB = 11;
	localparam int CFG_START_BIT = 12;

	// Status bits at OFS_STATUS
	localparam int ST_BUSY = 0;
	localparam int ST_ERROR = 1;
	localparam int ST_TX_EMPTY = 2;
	localparam int ST_RX_EMPTY = 3;
	localparam int ST_TX_FULL = 4;

endpackage

/* verilog/i2cIfs.sv */
// Queue port and controller-to-engine command port
// Engine handshake: cmdValid and cmd stay stable until done pulses,
// then cmdValid drops for at least one cycle

// Queue between the APB side and the transfer FSM
interface fifoIf;
	import apbI2cPkg::*;

	logic push;
	i2cByte_t pushData;
	logic pop;
	// Head entry, valid whenever empty is low
	i2cByte_t popData;
	logic full;
	logic empty;

	modport writer (output push, output pushData, input full, input empty);
	modport reader (output pop, input popData, input full, input empty);
	modport fifo (
		input push,
		input pushData,
		input pop,
		output popData,
		output full,
		output empty
	);
endinterface

// Command channel from i2cCtrl to i2cBitEngine
interface engIf;
	import apbI2cPkg::*;

	engCmd_e cmd;
	logic cmdValid;
	i2cByte_t wrByte;
	// Master acknowledges a read byte when set
	logic ackOut;
	logic done;
	i2cByte_t rdByte;
	// Slave acknowledged the written byte when set
	logic ackIn;

	modport ctrl (
		output cmd,
		output cmdValid,
		output wrByte,
		output ackOut,
		input done,
		input rdByte,
		input ackIn
	);
	modport engine (
		input cmd,
		input cmdValid,
		input wrByte,
		input ackOut,
		output done,
		output rdByte,
		output ackIn
	);
endinterface

/* verilog/syncFifo.sv */
// Single-clock first-word-fall-through queue
// FIFO_DEPTH must be a power of two so the pointers wrap by themselves
// Push while full and pop while empty are dropped without notice
module syncFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic PCLK,
	input logic PRESETn,
	fifoIf.fifo q
);
	import apbI2cPkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);
	// Occupancy value that means full
	localparam logic [AW:0] FULL_CNT = (AW + 1)'(FIFO_DEPTH);

	i2cByte_t mem [FIFO_DEPTH];
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;
	// One bit wider than the address so full and empty differ
	logic [AW:0] count;
	logic doPush;
	logic doPop;

	// Qualified strobes
	assign doPush = q.push && !q.full;
	assign doPop = q.pop && !q.empty;

	assign q.full = (count == FULL_CNT);
	assign q.empty = (count == '0);
	// Head entry shown without a pop
	assign q.popData = mem[rdPtr];

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (doPush)
		begin
			mem[wrPtr] <= q.pushData;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* verilog/apbRegs.sv */
// APB slave of the I2C master, no wait states
// While the error flag is set only CONFIG and STATUS are accessible
// Writing CONFIG clears the error flag; start is honoured only when idle
module apbRegs (
	input logic PCLK,
	input logic PRESETn,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input apbI2cPkg::apbWord_t PADDR,
	input apbI2cPkg::apbWord_t PWDATA,
	output apbI2cPkg::apbWord_t PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	fifoIf.writer txQ,
	fifoIf.reader rxQ,
	output logic startPulse,
	output logic cfgWrite,
	output apbI2cPkg::cfgReg_t cfg,
	output apbI2cPkg::cfgReg_t timeout,
	input logic busy,
	input logic error,
	output logic intTx,
	output logic intRx
);
	import apbI2cPkg::*;

	logic access;
	logic ofsTx;
	logic ofsRx;
	logic ofsCfg;
	logic ofsTmo;
	logic ofsSts;
	logic badAccess;
	logic tmoWrite;
	apbWord_t statusWord;

	////////////////////////////////////////////////////////////
	// Access phase decode
	////////////////////////////////////////////////////////////

	assign access = PSEL && PENABLE;
	assign ofsTx = (PADDR == OFS_TXDATA);
	assign ofsRx = (PADDR == OFS_RXDATA);
	assign ofsCfg = (PADDR == OFS_CONFIG);
	assign ofsTmo = (PADDR == OFS_TIMEOUT);
	assign ofsSts = (PADDR == OFS_STATUS);

	// Unmapped offset, TX overflow, RX underflow, or locked by error
	assign badAccess = !(ofsTx || ofsRx || ofsCfg || ofsTmo || ofsSts)
		|| (ofsTx && PWRITE && txQ.full)
		|| (ofsRx && !PWRITE && rxQ.empty)
		|| (error && !(ofsCfg || ofsSts));

	assign PREADY = access;
	assign PSLVERR = access && badAccess;

	// Queue strobes, only for accepted accesses
	assign txQ.push = access && PWRITE && ofsTx && !badAccess;
	assign txQ.pushData = PWDATA[7:0];
	assign rxQ.pop = access && !PWRITE && ofsRx && !badAccess;

	// CONFIG is never locked
	assign cfgWrite = access && PWRITE && ofsCfg;
	assign tmoWrite = access && PWRITE && ofsTmo && !badAccess;

	// Queue state interrupts
	assign intTx = txQ.empty;
	assign intRx = !rxQ.empty;

	////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfg <= '0;
			timeout <= '0;
			startPulse <= 1'b0;
		end
		else
		begin
			if (cfgWrite)
			begin
				cfg <= PWDATA[13:0];
			end
			if (tmoWrite)
			begin
				timeout <= PWDATA[13:0];
			end
			// One cycle after the write, cfg is already updated then
			startPulse <= cfgWrite && PWDATA[CFG_START_BIT] && !busy;
		end
	end

	// Status word
	always_comb
	begin
		statusWord = '0;
		statusWord[ST_BUSY] = busy;
		statusWord[ST_ERROR] = error;
		statusWord[ST_TX_EMPTY] = txQ.empty;
		statusWord[ST_RX_EMPTY] = rxQ.empty;
		statusWord[ST_TX_FULL] = txQ.full;
	end

	// Read mux
	always_comb
	begin
		case (PADDR)
			OFS_RXDATA: PRDATA = {24'd0, rxQ.popData};
			OFS_CONFIG: PRDATA = {18'd0, cfg};
			OFS_TIMEOUT: PRDATA = {18'd0, timeout};
			OFS_STATUS: PRDATA = statusWord;
			default: PRDATA = '0;
		endcase
	end

endmodule

/* verilog/i2cCtrl.sv */
// Transfer FSM for START, the address byte, the counted data bytes and STOP
// Slave NACK or timeout goes through ABORT and ends with STOP
// A zero timeout disables the busy limit of timeout x 256 cycles
module i2cCtrl (
	input logic PCLK,
	input logic PRESETn,
	input logic startPulse,
	input apbI2cPkg::cfgReg_t cfg,
	input apbI2cPkg::cfgReg_t timeout,
	input logic cfgWrite,
	fifoIf.reader txQ,
	fifoIf.writer rxQ,
	engIf.ctrl eng,
	output logic busy,
	output logic error
);
	import apbI2cPkg::*;

	ctrlState_e state;
	logic rdMode;
	logic [6:0] slvAddr;
	logic [3:0] bytesLeft;
	logic [21:0] tmoCnt;
	logic tmoHit;
	logic doneNow;
	logic canIssue;
	logic issue;
	engCmd_e nextCmd;

	// Engine finished the pending command
	assign doneNow = eng.cmdValid && eng.done;

	// Not checked in STOP or ABORT since both already end on STOP
	assign tmoHit = busy && (timeout != '0) && (tmoCnt >= {timeout, 8'd0})
		&& (state != STOP) && (state != ABORT);

	////////////////////////////////////////////////////////////
	// Next engine command
	////////////////////////////////////////////////////////////

	always_comb
	begin
		nextCmd = CMD_STOP;
		canIssue = 1'b0;
		case (state)
			START:
			begin
				nextCmd = CMD_START;
				canIssue = 1'b1;
			end
			ADDR:
			begin
				nextCmd = CMD_WRITE;
				canIssue = 1'b1;
			end
			// SCL stays low between bytes while a queue holds the transfer back
			// A receive push still in flight counts toward a full queue
			DATA:
			begin
				nextCmd = rdMode ? CMD_READ : CMD_WRITE;
				canIssue = rdMode ? !(rxQ.full || rxQ.push) : !txQ.empty;
			end
			STOP, ABORT: canIssue = 1'b1;
			default: canIssue = 1'b0;
		endcase
	end

	assign issue = canIssue && !eng.cmdValid;

	////////////////////////////////////////////////////////////
	// FSM and control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= IDLE;
			busy <= 1'b0;
			error <= 1'b0;
			rdMode <= 1'b0;
			bytesLeft <= '0;
			tmoCnt <= '0;
			eng.cmdValid <= 1'b0;
			eng.cmd <= CMD_STOP;
			eng.ackOut <= 1'b0;
			txQ.pop <= 1'b0;
			rxQ.push <= 1'b0;
		end
		else
		begin
			txQ.pop <= 1'b0;
			rxQ.push <= 1'b0;
			if (cfgWrite)
			begin
				error <= 1'b0;
			end
			if (busy)
			begin
				tmoCnt <= tmoCnt + 1'b1;
			end

			// Command handshake
			if (issue)
			begin
				eng.cmdValid <= 1'b1;
				eng.cmd <= nextCmd;
				// ACK every read byte but the last
				eng.ackOut <= (bytesLeft != 4'd1);
				// Byte leaves the TX queue as it is handed to the engine
				txQ.pop <= (state == DATA) && !rdMode;
			end
			if (doneNow)
			begin
				eng.cmdValid <= 1'b0;
			end

			case (state)
				IDLE:
				if (startPulse)
				begin
					busy <= 1'b1;
					tmoCnt <= '0;
					rdMode <= cfg[CFG_READ_BIT];
					bytesLeft <= cfg[CFG_CNT_MSB:CFG_CNT_LSB];
					state <= START;
				end
				START:
				if (doneNow)
				begin
					state <= ADDR;
				end
				ADDR:
				if (doneNow)
				begin
					state <= eng.ackIn ? DATA : ABORT;
				end
				DATA:
				if (doneNow)
				begin
					rxQ.push <= rdMode;
					if (!rdMode && !eng.ackIn)
					begin
						state <= ABORT;
					end
					else
					begin
						bytesLeft <= bytesLeft - 4'd1;
						if (bytesLeft == 4'd1)
						begin
							state <= STOP;
						end
					end
				end
				STOP:
				if (doneNow)
				begin
					busy <= 1'b0;
					state <= IDLE;
				end
				// Let a pending byte finish before STOP
				ABORT:
				begin
					error <= 1'b1;
					if (doneNow && eng.cmd == CMD_STOP)
					begin
						busy <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase

			if (tmoHit)
			begin
				state <= ABORT;
			end
		end
	end

	// Payload registers
	always_ff @(posedge PCLK)
	begin
		if (state == IDLE && startPulse)
		begin
			slvAddr <= cfg[CFG_ADDR_MSB:0];
		end
		if (issue)
		begin
			eng.wrByte <= (state == ADDR) ? {slvAddr, rdMode} : txQ.popData;
		end
		if (doneNow && state == DATA && rdMode)
		begin
			rxQ.pushData <= eng.rdByte;
		end
	end

endmodule

/* verilog/i2cBitEngine.sv */
// I2C bit engine, one START, STOP, byte write or byte read per command
// SCL_HALF is PCLK cycles per SCL half-period and must be 2 or more
// START assumes an idle bus; byte and STOP commands start with SCL low
module i2cBitEngine #(
	parameter int SCL_HALF = 4
) (
	input logic PCLK,
	input logic PRESETn,
	engIf.engine eng,
	output logic scl,
	output logic sdaOut,
	output logic sdaOe,
	input logic sdaIn
);
	import apbI2cPkg::*;

	localparam int DIV_W = $clog2(SCL_HALF);
	localparam logic [DIV_W-1:0] HALF_END = DIV_W'(SCL_HALF - 1);
	// SDA moves in the middle of the low half, away from both SCL edges
	localparam logic [DIV_W-1:0] HALF_MID = DIV_W'((SCL_HALF - 1) / 2);
	// Nine bits, two halves each
	localparam logic [4:0] BYTE_LAST = 5'd17;

	logic [DIV_W-1:0] divCnt;
	logic [4:0] phase;
	logic running;
	engCmd_e curCmd;
	logic isByte;
	logic accept;
	logic halfTick;
	logic midLow;
	logic [8:0] loadBits;
	logic [8:0] shiftReg;
	i2cByte_t rxShift;

	assign accept = !running && eng.cmdValid && !eng.done;
	assign halfTick = running && (divCnt == HALF_END);
	assign isByte = (curCmd == CMD_WRITE) || (curCmd == CMD_READ);
	// Even phase is the SCL low half
	assign midLow = running && isByte && !phase[0] && (divCnt == HALF_MID);

	// Read: data released, ninth bit is the master ACK
	assign loadBits = (eng.cmd == CMD_READ) ? {8'hFF, !eng.ackOut} : {eng.wrByte, 1'b1};

	// Open-drain level the master puts on SDA
	assign sdaOut = !sdaOe;
	assign eng.rdByte = rxShift;

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			running <= 1'b0;
			curCmd <= CMD_STOP;
			phase <= '0;
			divCnt <= '0;
			scl <= 1'b1;
			sdaOe <= 1'b0;
			eng.done <= 1'b0;
			eng.ackIn <= 1'b0;
		end
		else
		begin
			eng.done <= 1'b0;
			if (accept)
			begin
				running <= 1'b1;
				curCmd <= eng.cmd;
				phase <= '0;
				divCnt <= '0;
				// STOP pulls SDA low while SCL is still low
				if (eng.cmd == CMD_STOP)
				begin
					scl <= 1'b0;
					sdaOe <= 1'b1;
				end
			end
			else if (halfTick)
			begin
				divCnt <= '0;
				phase <= phase + 5'd1;
				case (curCmd)
					// SDA falls under high SCL, then SCL falls
					CMD_START:
					if (phase == 5'd0)
					begin
						sdaOe <= 1'b1;
					end
					else
					begin
						scl <= 1'b0;
						running <= 1'b0;
						eng.done <= 1'b1;
					end
					// SCL rises, then SDA is released
					CMD_STOP:
					if (phase == 5'd0)
					begin
						scl <= 1'b1;
					end
					else
					begin
						sdaOe <= 1'b0;
						running <= 1'b0;
						eng.done <= 1'b1;
					end
					default:
					if (!phase[0])
					begin
						scl <= 1'b1;
					end
					else
					begin
						scl <= 1'b0;
						// Ninth bit is the acknowledge, low means ACK
						if (phase == BYTE_LAST)
						begin
							eng.ackIn <= !sdaIn;
							running <= 1'b0;
							eng.done <= 1'b1;
						end
					end
				endcase
			end
			else if (running)
			begin
				divCnt <= divCnt + 1'b1;
				if (midLow)
				begin
					sdaOe <= !shiftReg[8];
				end
			end
		end
	end

	// Bit shifters
	always_ff @(posedge PCLK)
	begin
		if (accept)
		begin
			shiftReg <= loadBits;
		end
		else if (midLow)
		begin
			shiftReg <= {shiftReg[7:0], 1'b1};
		end
		// Sample at the end of each high half, data bits only
		if (halfTick && isByte && phase[0] && phase != BYTE_LAST)
		begin
			rxShift <= {rxShift[6:0], sdaIn};
		end
	end

endmodule

/* verilog/apbI2cTop.sv */
// APB I2C master, single master, 7-bit addressing only
// No clock stretching and no repeated START
// sdaOe set means SDA is pulled low; scl is driven push-pull
module apbI2cTop #(
	parameter int FIFO_DEPTH = 8,
	parameter int SCL_HALF = 4
) (
	input logic PCLK,
	input logic PRESETn,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input apbI2cPkg::apbWord_t PADDR,
	input apbI2cPkg::apbWord_t PWDATA,
	output apbI2cPkg::apbWord_t PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic scl,
	output logic sdaOut,
	output logic sdaOe,
	input logic sdaIn,
	output logic intTx,
	output logic intRx
);
	import apbI2cPkg::*;

	logic startPulse;
	logic cfgWrite;
	cfgReg_t cfg;
	cfgReg_t timeout;
	logic busy;
	logic error;

	fifoIf txQ ();
	fifoIf rxQ ();
	engIf eng ();

	////////////////////////////////////////////////////////////
	// APB side
	////////////////////////////////////////////////////////////

	apbRegs apbRegs_i (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.txQ(txQ.writer),
		.rxQ(rxQ.reader),
		.startPulse(startPulse),
		.cfgWrite(cfgWrite),
		.cfg(cfg),
		.timeout(timeout),
		.busy(busy),
		.error(error),
		.intTx(intTx),
		.intRx(intRx)
	);

	// Transmit and receive queues
	syncFifo #(.FIFO_DEPTH(FIFO_DEPTH)) txFifo_i (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.q(txQ.fifo)
	);

	syncFifo #(.FIFO_DEPTH(FIFO_DEPTH)) rxFifo_i (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.q(rxQ.fifo)
	);

	////////////////////////////////////////////////////////////
	// I2C side
	////////////////////////////////////////////////////////////

	i2cCtrl i2cCtrl_i (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.startPulse(startPulse),
		.cfg(cfg),
		.timeout(timeout),
		.cfgWrite(cfgWrite),
		.txQ(txQ.reader),
		.rxQ(rxQ.writer),
		.eng(eng.ctrl),
		.busy(busy),
		.error(error)
	);

	i2cBitEngine #(.SCL_HALF(SCL_HALF)) i2cBitEngine_i (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.eng(eng.engine),
		.scl(scl),
		.sdaOut(sdaOut),
		.sdaOe(sdaOe),
		.sdaIn(sdaIn)
	);

endmodule

/* verif/apbI2c_chk.sv */
// Concurrent checks on the APB register block, bound into apbRegs
// Assumes a zero wait state APB slave and queue strobes from apbRegs only
module apbI2c_chk (
	input logic PCLK,
	input logic PRESETn,
	input logic PSEL,
	input logic PENABLE,
	input logic PREADY,
	input logic txPush,
	input logic rxPop,
	input logic txEmpty,
	input logic rxEmpty,
	input logic intTx,
	input logic intRx
);
	timeunit 1ns;
	timeprecision 100ps;

	// Number of failed assertions so far
	int failCount = 0;

	// No wait states, every access phase completes at once
	pReadyInAccess: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(PSEL && PENABLE) |-> PREADY)
	else
	begin
		$error("PREADY low in an APB access phase");
		failCount = failCount + 1;
	end

	// TX interrupt is the TX queue empty flag
	intTxFollowsEmpty: assert property (@(posedge PCLK) disable iff (!PRESETn)
		intTx == txEmpty)
	else
	begin
		$error("intTx differs from the TX queue empty flag");
		failCount = failCount + 1;
	end

	// RX interrupt means read data is waiting
	intRxFollowsData: assert property (@(posedge PCLK) disable iff (!PRESETn)
		intRx == !rxEmpty)
	else
	begin
		$error("intRx differs from the inverse of the RX queue empty flag");
		failCount = failCount + 1;
	end

	// Queue strobes only come from a completed access
	strobeInAccess: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(txPush || rxPop) |-> (PSEL && PENABLE))
	else
	begin
		$error("Queue push or pop outside an APB access phase");
		failCount = failCount + 1;
	end

endmodule

/* verif/tbApbI2c.sv */
// Testbench for the APB I2C master with a byte level I2C slave model
// The slave ACKs address 7'h2A only and supplies LCG bytes on reads
// No clock stretching on the bus
// The slave reacts 1 ns after SCL falls
module tbApbI2c;
	timeunit 1ns;
	timeprecision 100ps;
	import apbI2cPkg::*;

	localparam int FIFO_DEPTH = 8;
	localparam int SCL_HALF = 4;
	localparam int CLK_NS = 8;
	localparam int WATCHDOG_NS = 4 * 16 * 9 * 2 * SCL_HALF * CLK_NS * 2;
	// Status polls allowed while waiting on one busy edge
	localparam int POLL_LIMIT = 16 * 9 * 2 * SCL_HALF;
	localparam logic [6:0] SLAVE_ADDR = 7'h2A;
	localparam logic [31:0] SEED = 32'h010cdf7d;

	logic PCLK;
	logic PRESETn;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	apbWord_t PADDR;
	apbWord_t PWDATA;
	apbWord_t PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic scl;
	logic sdaOut;
	logic sdaOe;
	logic sdaIn;
	logic intTx;
	logic intRx;

	int errors = 0;
	logic [31:0] stimState = SEED;

	// Slave model state
	logic slaveLow = 1'b0;
	logic sdaLine;
	logic prevScl;
	logic prevSda;
	logic active = 1'b0;
	logic sawHigh = 1'b0;
	logic isAddr = 1'b0;
	logic addrOk = 1'b0;
	logic rdMode = 1'b0;
	logic sending = 1'b0;
	logic masterAck = 1'b0;
	int bitIdx = 0;
	i2cByte_t shiftIn = '0;
	i2cByte_t txBits = '0;
	logic [31:0] slaveState = SEED;
	i2cByte_t wrStore [$];
	i2cByte_t expRx [$];

	apbI2cTop #(.FIFO_DEPTH(FIFO_DEPTH), .SCL_HALF(SCL_HALF)) dut_i (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.scl(scl),
		.sdaOut(sdaOut),
		.sdaOe(sdaOe),
		.sdaIn(sdaIn),
		.intTx(intTx),
		.intRx(intRx)
	);

	bind apbRegs apbI2c_chk chk_i (
		.PCLK(PCLK),
		.PRESETn(PRESETn),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PREADY(PREADY),
		.txPush(txQ.push),
		.rxPop(rxQ.pop),
		.txEmpty(txQ.empty),
		.rxEmpty(rxQ.empty),
		.intTx(intTx),
		.intRx(intRx)
	);

	// Open-drain line where the master puts sdaOut while sdaOe is set
	assign sdaLine = (sdaOe ? sdaOut : 1'b1) && !slaveLow;
	assign sdaIn = sdaLine;

	initial
	begin
		PCLK = 1'b0;
		forever
		begin
			#(CLK_NS / 2) PCLK = ~PCLK;
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic apbWord_t cfgWord(input logic [6:0] addr, input logic rd,
		input logic [3:0] cnt, input logic go);
		return {18'd0, 1'b0, go, cnt, rd, addr};
	endfunction

	////////////////////////////////////////////////////////////
	// I2C slave model
	////////////////////////////////////////////////////////////

	always @(scl or sdaLine)
	begin
		if (scl === 1'b1 && prevScl === 1'b1 && sdaLine !== prevSda)
		begin
			// SDA moving under high SCL is START when falling and STOP when rising
			active = (sdaLine === 1'b0);
			isAddr = 1'b1;
			addrOk = 1'b0;
			rdMode = 1'b0;
			sending = 1'b0;
			sawHigh = 1'b0;
			bitIdx = 0;
			slaveLow <= #1 1'b0;
		end
		else if (active && scl === 1'b1 && prevScl === 1'b0)
		begin
			sawHigh = 1'b1;
			if (bitIdx < 8)
			begin
				shiftIn = {shiftIn[6:0], sdaLine};
			end
			else
			begin
				masterAck = !sdaLine;
			end
		end
		// The fall that ends START has no high half before it
		else if (active && sawHigh && scl === 1'b0 && prevScl === 1'b1)
		begin
			sawHigh = 1'b0;
			bitIdx++;
			if (bitIdx == 8)
			begin
				sending = 1'b0;
				if (isAddr)
				begin
					addrOk = (shiftIn[7:1] == SLAVE_ADDR);
					rdMode = shiftIn[0];
					slaveLow <= #1 addrOk;
				end
				else if (addrOk && !rdMode)
				begin
					wrStore.push_back(shiftIn);
					slaveLow <= #1 1'b1;
				end
				else
				begin
					// Master drives its own ACK on reads
					slaveLow <= #1 1'b0;
				end
			end
			else if (bitIdx == 9)
			begin
				bitIdx = 0;
				if (addrOk && rdMode && (isAddr || masterAck))
				begin
					slaveState = lcgNext(slaveState);
					txBits = slaveState[23:16];
					expRx.push_back(txBits);
					sending = 1'b1;
					slaveLow <= #1 !txBits[7];
				end
				else
				begin
					slaveLow <= #1 1'b0;
				end
				isAddr = 1'b0;
			end
			else if (sending)
			begin
				txBits = {txBits[6:0], 1'b0};
				slaveLow <= #1 !txBits[7];
			end
		end
		prevScl = scl;
		prevSda = sdaLine;
	end

	////////////////////////////////////////////////////////////
	// APB access and checks
	////////////////////////////////////////////////////////////

	task automatic apbAccess(input logic wr, input apbWord_t addr, input apbWord_t wdata,
		output apbWord_t rdata, output logic err);
		@(posedge PCLK);
		#1;
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = wr;
		PADDR = addr;
		PWDATA = wdata;
		@(posedge PCLK);
		#1;
		PENABLE = 1'b1;
		// Access phase outputs are settled by the falling edge
		@(negedge PCLK);
		rdata = PRDATA;
		err = PSLVERR;
		@(posedge PCLK);
		#1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
	endtask

	task automatic apbWrite(input apbWord_t addr, input apbWord_t data, output logic err);
		apbWord_t unused;
		apbAccess(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input apbWord_t addr, output apbWord_t data, output logic err);
		apbAccess(1'b0, addr, '0, data, err);
	endtask

	task automatic checkEq(input string what, input apbWord_t got, input apbWord_t exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch at %0d ns: %s, got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// Polls the status register until busy reaches the level
	task automatic waitBusy(input logic level);
		apbWord_t sts;
		logic err;
		int polls;
		polls = 0;
		apbRead(OFS_STATUS, sts, err);
		while (sts[ST_BUSY] !== level && polls < POLL_LIMIT)
		begin
			apbRead(OFS_STATUS, sts, err);
			polls++;
		end
		if (sts[ST_BUSY] !== level)
		begin
			$display("Busy did not reach %b within %0d status polls", level, POLL_LIMIT);
			errors++;
		end
	endtask

	task automatic pushRandom(input int n, input logic expErr);
		i2cByte_t b;
		logic err;
		for (int i = 0; i < n; i++)
		begin
			stimState = lcgNext(stimState);
			b = stimState[23:16];
			apbWrite(OFS_TXDATA, {24'd0, b}, err);
			checkFlag("PSLVERR on TX push", err, expErr);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		apbWord_t rd;
		logic err;
		logic [31:0] firstTx;
		int wrBase;
		int total;
		PRESETn = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		repeat (4) @(posedge PCLK);
		#1;
		PRESETn = 1'b1;

		// Register access and map
		apbWrite(OFS_CONFIG, cfgWord(7'h2A, 1'b0, 4'd11, 1'b0), err);
		apbWrite(OFS_TIMEOUT, 32'd40, err);
		apbRead(OFS_CONFIG, rd, err);
		checkEq("CONFIG readback", rd, cfgWord(7'h2A, 1'b0, 4'd11, 1'b0));
		apbRead(OFS_STATUS, rd, err);
		checkEq("STATUS after reset", rd, (32'd1 << ST_TX_EMPTY) | (32'd1 << ST_RX_EMPTY));
		apbRead(32'd20, rd, err);
		checkFlag("PSLVERR at offset 20", err, 1'b1);

		// Write transfer of three bytes
		firstTx = lcgNext(stimState);
		wrBase = wrStore.size();
		pushRandom(3, 1'b0);
		apbWrite(OFS_CONFIG, cfgWord(SLAVE_ADDR, 1'b0, 4'd3, 1'b1), err);
		waitBusy(1'b1);
		waitBusy(1'b0);
		checkEq("bytes stored by slave", 32'(wrStore.size() - wrBase), 32'd3);
		for (int i = 0; i < 3 && wrBase + i < wrStore.size(); i++)
		begin
			checkEq("byte written to slave", {24'd0, wrStore[wrBase + i]},
				{24'd0, firstTx[23:16]});
			firstTx = lcgNext(firstTx);
		end
		apbRead(OFS_STATUS, rd, err);
		checkEq("STATUS after write", rd, (32'd1 << ST_TX_EMPTY) | (32'd1 << ST_RX_EMPTY));
		checkFlag("intTx after write", intTx, 1'b1);

		// Read transfer of four bytes with the last one NACKed
		apbWrite(OFS_CONFIG, cfgWord(SLAVE_ADDR, 1'b1, 4'd4, 1'b1), err);
		waitBusy(1'b1);
		waitBusy(1'b0);
		checkFlag("intRx after read", intRx, 1'b1);
		checkEq("bytes sent by slave", 32'(expRx.size()), 32'd4);
		for (int i = 0; i < 4; i++)
		begin
			apbRead(OFS_RXDATA, rd, err);
			checkFlag("PSLVERR on RX read", err, 1'b0);
			if (i < expRx.size())
			begin
				checkEq("RX data", rd, {24'd0, expRx[i]});
			end
		end
		apbRead(OFS_RXDATA, rd, err);
		checkFlag("PSLVERR on empty RX read", err, 1'b1);

		// Address NACK sets the error flag
		apbWrite(OFS_CONFIG, cfgWord(7'h11, 1'b1, 4'd1, 1'b1), err);
		waitBusy(1'b1);
		waitBusy(1'b0);
		apbRead(OFS_STATUS, rd, err);
		checkFlag("error after NACK", rd[ST_ERROR], 1'b1);
		apbWrite(OFS_TXDATA, 32'h5A, err);
		checkFlag("PSLVERR on TX push during error", err, 1'b1);
		apbWrite(OFS_CONFIG, cfgWord(7'h11, 1'b0, 4'd1, 1'b0), err);
		apbRead(OFS_STATUS, rd, err);
		checkFlag("error after CONFIG write", rd[ST_ERROR], 1'b0);

		// Timeout with the TX queue starved
		apbWrite(OFS_TIMEOUT, 32'd1, err);
		pushRandom(1, 1'b0);
		apbWrite(OFS_CONFIG, cfgWord(SLAVE_ADDR, 1'b0, 4'd15, 1'b1), err);
		waitBusy(1'b1);
		waitBusy(1'b0);
		apbRead(OFS_STATUS, rd, err);
		checkFlag("error after timeout", rd[ST_ERROR], 1'b1);
		checkFlag("SCL released after abort", scl, 1'b1);
		checkFlag("SDA released after abort", sdaLine, 1'b1);
		apbWrite(OFS_CONFIG, '0, err);

		// TX queue overflow on the last push only
		pushRandom(FIFO_DEPTH, 1'b0);
		pushRandom(1, 1'b1);
		apbRead(OFS_STATUS, rd, err);
		checkFlag("txFull after filling", rd[ST_TX_FULL], 1'b1);

		total = errors + dut_i.apbRegs_i.chk_i.failCount;
		$display("Errors: %0d check failures, %0d assertion failures", errors,
			dut_i.apbRegs_i.chk_i.failCount);
		if (total == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog sized from four full length transfers with a margin of two
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("Errors: %0d check failures, %0d assertion failures", errors,
			dut_i.apbRegs_i.chk_i.failCount);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* filelist.f */
verilog/apbI2cPkg.sv
verilog/i2cIfs.sv
verilog/syncFifo.sv
verilog/apbRegs.sv
verilog/i2cCtrl.sv
verilog/i2cBitEngine.sv
verilog/apbI2cTop.sv
verif/apbI2c_chk.sv
verif/tbApbI2c.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -j 0 --timescale 1ns/100ps
TOP = tbApbI2c
FILELIST = filelist.f
OBJ_DIR = obj_dir
LOG = sim.log
RUN_FLAGS = +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(EXE) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
